/* bench/smem_patterns.txt */
// op tag addr byteen wdata expect
// op 0 is a read, 1 a write, f ends the list; tag bit 0 picks the bank
1 00 010 f 11223344 00000000
1 00 010 1 aaaaaa55 00000000
1 00 010 6 66778899 00000000
0 02 010 0 00000000 11778855
1 01 010 f cafef00d 00000000
1 01 010 8 5a000000 00000000
0 03 010 0 00000000 5afef00d
0 05 010 0 00000000 5afef00d
0 04 010 0 00000000 11778855
1 00 020 f 00000020 00000000
1 00 021 f 00000021 00000000
1 00 022 f a5a5a5a5 00000000
1 00 023 f 0f0f0f0f 00000000
1 01 020 f 10000020 00000000
1 01 021 f 10000021 00000000
1 01 022 f 5a5a5a5a 00000000
1 01 023 f f0f0f0f0 00000000
1 01 030 f 01020304 00000000
1 01 030 3 0000abcd 00000000
1 00 031 f ffffffff 00000000
1 00 031 5 00120034 00000000
0 07 020 0 00000000 10000020
0 06 020 0 00000000 00000020
0 09 021 0 00000000 10000021
0 08 021 0 00000000 00000021
0 0b 022 0 00000000 5a5a5a5a
0 0a 022 0 00000000 a5a5a5a5
0 0d 023 0 00000000 f0f0f0f0
0 0c 023 0 00000000 0f0f0f0f
0 0f 030 0 00000000 0102abcd
0 0e 031 0 00000000 ff12ff34
0 11 010 0 00000000 5afef00d
0 10 010 0 00000000 11778855
0 13 020 0 00000000 10000020
0 12 023 0 00000000 0f0f0f0f
f 00 000 0 00000000 00000000

/* list.f */
rtl/smem_pkg.sv
rtl/stream_switch.sv
rtl/stream_arb.sv
rtl/smem_switch.sv
rtl/smem_bank.sv
rtl/smem_subsys.sv
bench/tb_smem_subsys.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f list.f --top-module tb_smem_subsys -o sim_smem
./obj_dir/sim_smem 2>&1 | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "run passed"
    exit 0
else
    echo "run failed, see sim.log"
    exit 1
fi

/* bench/tb_smem_subsys.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_smem_subsys;

    import smem_pkg::*;

    localparam int          MAX_PATTERNS = 64;
    localparam int          FIELDS       = 6;     // op, tag, addr, byteen, wdata, expect.
    localparam int          PAT_W        = $clog2(FIELDS * MAX_PATTERNS);
    localparam logic [31:0] OP_READ      = 32'h0;
    localparam logic [31:0] OP_WRITE     = 32'h1;
    localparam logic [31:0] OP_END       = 32'hf;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    logic      req_ready;
    core_req_t req;
    logic      rsp_valid;
    logic      rsp_ready;
    core_rsp_t rsp;

    logic [31:0]           pat_mem [FIELDS*MAX_PATTERNS];
    logic [(1<<tag_w)-1:0] issued;                 // reads sent per tag.
    logic [(1<<tag_w)-1:0] answered;               // reads returned per tag.
    logic [data_w-1:0]     exp_data [1<<tag_w];
    int                    num_patterns;
    int                    limit;
    int                    cycles;
    integer                seed;
    logic [31:0]           rnd;

    smem_subsys #(
        .BUFFERED_REQ (1'b1),
        .TAG_SEL_IDX  (0),
        .FAST_LATENCY (1),
        .SLOW_LATENCY (3)
    ) i_smem_subsys (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "run stopped at first error");
        end
    endtask

    function automatic logic [31:0] field(input int p, input int f);
        logic [PAT_W-1:0] at;
        at = PAT_W'(FIELDS * p + f);
        return pat_mem[at];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clock, back-pressure, timeout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin : drive_rsp_ready
        seed      = 32'h4088e3a2;
        rsp_ready = 1'b0;
        forever begin
            @(posedge clk);
            rnd = $random(seed);
            rsp_ready <= (rnd[1:0] != 2'b00);      // high three cycles in four.
        end
    end

    initial begin : watchdog
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (limit > 0 && cycles >= limit) begin
                stop_with_error($sformatf("timeout after %0d cycles, reads still pending",
                                          cycles));
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response scoreboard
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : monitor
        answered = '0;
        forever begin
            @(posedge clk);
            if (rst_n && rsp_valid && rsp_ready) begin
                if (!issued[rsp.tag] || answered[rsp.tag]) begin
                    stop_with_error($sformatf("unexpected response with tag 0x%h", rsp.tag));
                end else begin
                    check_value($sformatf("rsp.data (tag 0x%h)", rsp.tag), rsp.data,
                                exp_data[rsp.tag]);
                    answered[rsp.tag] = 1'b1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : main_seq
        logic [31:0]         op;
        logic [tag_w-1:0]    tag;
        logic [addr_w-1:0]   addr;
        logic [byteen_w-1:0] byteen;
        logic [data_w-1:0]   wdata;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        issued       = '0;
        limit        = 0;
        num_patterns = 0;
        $readmemh("bench/smem_patterns.txt", pat_mem);
        while (num_patterns < MAX_PATTERNS && field(num_patterns, 0) != OP_END) begin
            num_patterns++;
        end
        if (num_patterns == 0) begin
            stop_with_error("pattern file is missing or holds no patterns");
        end else if (num_patterns == MAX_PATTERNS) begin
            stop_with_error("pattern file has no end marker");
        end else begin
            limit = 20 * num_patterns + 200;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // idle after reset.
        repeat (4) begin
            @(posedge clk);
            check_value("rsp_valid", 32'(rsp_valid), 32'h0);
            check_value("req_ready", 32'(req_ready), 32'h1);
        end

        for (int i = 0; i < num_patterns; i++) begin
            op     = field(i, 0);
            tag    = tag_w'(field(i, 1));
            addr   = addr_w'(field(i, 2));
            byteen = byteen_w'(field(i, 3));
            wdata  = field(i, 4);
            if (op != OP_READ && op != OP_WRITE) begin
                stop_with_error($sformatf("pattern %0d has an unknown operation", i));
            end else if (op == OP_READ && issued[tag]) begin
                stop_with_error($sformatf("pattern %0d reuses read tag 0x%h", i, tag));
            end else begin
                if (op == OP_READ) begin
                    issued[tag]   = 1'b1;
                    exp_data[tag] = field(i, 5);
                end
                req_valid <= 1'b1;
                req       <= '{tag: tag, addr: addr, rw: (op == OP_WRITE),
                               byteen: byteen, data: wdata};
                @(posedge clk);
                while (!req_ready) @(posedge clk);   // held until accepted.
            end
        end
        req_valid <= 1'b0;

        while (issued != answered) @(posedge clk);
        repeat (8) @(posedge clk);                // catch stray responses.
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/smem_subsys.sv */
`timescale 1ns/100ps
`default_nettype none

module smem_subsys #(
    parameter bit BUFFERED_REQ = 1,
    parameter int TAG_SEL_IDX  = 0,
    parameter int FAST_LATENCY = 1,
    parameter int SLOW_LATENCY = 3
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       req_valid,
    output logic                      req_ready,
    input  wire smem_pkg::core_req_t  req,
    output logic                      rsp_valid,
    input  wire                       rsp_ready,
    output smem_pkg::core_rsp_t       rsp
);

    import smem_pkg::*;

    logic [num_banks-1:0]      bank_req_valid;
    logic [num_banks-1:0]      bank_req_ready;
    bank_req_t [num_banks-1:0] bank_req;
    logic [num_banks-1:0]      bank_rsp_valid;
    logic [num_banks-1:0]      bank_rsp_ready;
    bank_rsp_t [num_banks-1:0] bank_rsp;

    smem_switch #(
        .BUFFERED_REQ (BUFFERED_REQ),
        .TAG_SEL_IDX  (TAG_SEL_IDX)
    ) i_smem_switch (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req            (req),
        .rsp_valid      (rsp_valid),
        .rsp_ready      (rsp_ready),
        .rsp            (rsp),
        .bank_req_valid (bank_req_valid),
        .bank_req_ready (bank_req_ready),
        .bank_req       (bank_req),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp_ready (bank_rsp_ready),
        .bank_rsp       (bank_rsp)
    );

    // bank 0 is the scratchpad.
    smem_bank #(
        .LATENCY (FAST_LATENCY)
    ) i_bank_fast (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (bank_req_valid[0]),
        .req_ready (bank_req_ready[0]),
        .req       (bank_req[0]),
        .rsp_valid (bank_rsp_valid[0]),
        .rsp_ready (bank_rsp_ready[0]),
        .rsp       (bank_rsp[0])
    );

    // bank 1 is the local store.
    smem_bank #(
        .LATENCY (SLOW_LATENCY)
    ) i_bank_slow (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (bank_req_valid[1]),
        .req_ready (bank_req_ready[1]),
        .req       (bank_req[1]),
        .rsp_valid (bank_rsp_valid[1]),
        .rsp_ready (bank_rsp_ready[1]),
        .rsp       (bank_rsp[1])
    );

endmodule

`default_nettype wire

/* rtl/smem_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module smem_bank #(
    parameter int LATENCY = 1,
    parameter int DEPTH   = 256
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       req_valid,
    output logic                      req_ready,
    input  wire smem_pkg::bank_req_t  req,
    output logic                      rsp_valid,
    input  wire                       rsp_ready,
    output smem_pkg::bank_rsp_t       rsp
);

    import smem_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    logic [data_w-1:0] mem [DEPTH];

    logic [IDX_W-1:0]           idx;
    logic                       stall;
    logic                       req_fire;
    logic                       rd_fire;
    logic                       wr_fire;
    logic [LATENCY-1:0]         stage_valid;
    bank_rsp_t [LATENCY-1:0]    stage_data;

    assign idx      = req.addr[IDX_W-1:0];        // low word bits only.
    assign stall    = stage_valid[LATENCY-1] && !rsp_ready;
    assign req_ready = !stall;
    assign req_fire = req_valid && req_ready;
    assign rd_fire  = req_fire && !req.rw;
    assign wr_fire  = req_fire && req.rw;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int k = 0; k < byteen_w; k++) begin
                if (req.byteen[k]) begin
                    mem[idx][8*k +: 8] <= req.data[8*k +: 8];   // merge enabled bytes.
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read pipe
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= '0;
        end else if (!stall) begin
            stage_valid[0] <= rd_fire;
            for (int s = 1; s < LATENCY; s++) begin
                stage_valid[s] <= stage_valid[s-1];
            end
        end
    end

    // data moves with valid through bubbles too.
    always_ff @(posedge clk) begin
        if (!stall) begin
            stage_data[0] <= '{tag: req.tag, data: mem[idx]};
            for (int s = 1; s < LATENCY; s++) begin
                stage_data[s] <= stage_data[s-1];
            end
        end
    end

    assign rsp_valid = stage_valid[LATENCY-1];
    assign rsp       = stage_data[LATENCY-1];

endmodule

`default_nettype wire

/* rtl/smem_switch.sv */
`timescale 1ns/100ps
`default_nettype none

module smem_switch #(
    parameter bit BUFFERED_REQ = 0,
    parameter int TAG_SEL_IDX  = 0
) (
    input  wire                                              clk,
    input  wire                                              rst_n,
    input  wire                                              req_valid,
    output logic                                             req_ready,
    input  wire smem_pkg::core_req_t                         req,
    output logic                                             rsp_valid,
    input  wire                                              rsp_ready,
    output smem_pkg::core_rsp_t                              rsp,
    output logic [smem_pkg::num_banks-1:0]                   bank_req_valid,
    input  wire [smem_pkg::num_banks-1:0]                    bank_req_ready,
    output smem_pkg::bank_req_t [smem_pkg::num_banks-1:0]    bank_req,
    input  wire [smem_pkg::num_banks-1:0]                    bank_rsp_valid,
    output logic [smem_pkg::num_banks-1:0]                   bank_rsp_ready,
    input  wire smem_pkg::bank_rsp_t [smem_pkg::num_banks-1:0] bank_rsp
);

    import smem_pkg::*;

    // bits of the tag below the select field.
    localparam logic [tag_w-1:0] LOW_MASK = (tag_w'(1) << TAG_SEL_IDX) - 1'b1;

    function automatic bank_tag_t strip_sel(input logic [tag_w-1:0] tag);
        logic [tag_w-1:0] upper;
        upper = (tag >> (TAG_SEL_IDX + sel_w)) << TAG_SEL_IDX;
        return bank_tag_t'(upper | (tag & LOW_MASK));
    endfunction

    function automatic logic [tag_w-1:0] insert_sel(input bank_tag_t btag,
                                                    input logic [sel_w-1:0] sel);
        logic [tag_w-1:0] wide;
        wide = tag_w'(btag);
        return ((wide & ~LOW_MASK) << sel_w) | (wide & LOW_MASK)
               | (tag_w'(sel) << TAG_SEL_IDX);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [sel_w-1:0] req_sel;
    bank_req_t        req_out;

    assign req_sel = req.tag[TAG_SEL_IDX +: sel_w];
    assign req_out = '{tag:    strip_sel(req.tag),
                       addr:   req.addr,
                       rw:     req.rw,
                       byteen: req.byteen,
                       data:   req.data};

    stream_switch #(
        .NUM_OUTPUTS (num_banks),
        .BUFFERED    (BUFFERED_REQ),
        .payload_t   (bank_req_t)
    ) i_req_switch (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel       (req_sel),
        .valid_in  (req_valid),
        .ready_in  (req_ready),
        .data_in   (req_out),
        .valid_out (bank_req_valid),
        .ready_out (bank_req_ready),
        .data_out  (bank_req)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    core_rsp_t [num_banks-1:0] rsp_in;

    for (genvar b = 0; b < num_banks; b++) begin : g_rsp
        assign rsp_in[b] = '{tag:  insert_sel(bank_rsp[b].tag, sel_w'(b)),
                             data: bank_rsp[b].data};
    end

    stream_arb #(
        .NUM_INPUTS (num_banks),
        .payload_t  (core_rsp_t)
    ) i_rsp_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (bank_rsp_valid),
        .ready_in  (bank_rsp_ready),
        .data_in   (rsp_in),
        .valid_out (rsp_valid),
        .ready_out (rsp_ready),
        .data_out  (rsp)
    );

endmodule

`default_nettype wire

/* rtl/stream_arb.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_arb #(
    parameter int  NUM_INPUTS = 2,
    parameter type payload_t  = logic [31:0]
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire [NUM_INPUTS-1:0]            valid_in,
    output logic [NUM_INPUTS-1:0]           ready_in,
    input  wire payload_t [NUM_INPUTS-1:0]  data_in,
    output logic                            valid_out,
    input  wire                             ready_out,
    output payload_t                        data_out
);

    localparam int               IDX_W = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1;
    localparam logic [IDX_W-1:0] LAST  = IDX_W'(NUM_INPUTS - 1);

    logic [IDX_W-1:0] ptr;       // highest priority input.
    logic [IDX_W-1:0] grant;
    logic             out_fire;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // grant search
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // walk from the far end back to ptr, so the closest valid wins.
    always_comb begin : grant_search
        int cand;
        grant = ptr;
        for (int k = NUM_INPUTS - 1; k >= 0; k--) begin
            cand = int'(ptr) + k;
            if (cand >= NUM_INPUTS) begin
                cand = cand - NUM_INPUTS;              // wrap.
            end
            if (valid_in[cand]) begin
                grant = IDX_W'(cand);
            end
        end
    end

    assign valid_out = |valid_in;
    assign data_out  = data_in[grant];
    assign out_fire  = valid_out && ready_out;

    for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_ready
        assign ready_in[i] = ready_out && (grant == IDX_W'(i));
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (out_fire) begin
            if (grant == LAST) begin
                ptr <= '0;
            end else begin
                ptr <= grant + 1'b1;                   // one past the winner.
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/stream_switch.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_switch #(
    parameter int  NUM_OUTPUTS = 2,
    parameter bit  BUFFERED    = 0,
    parameter type payload_t   = logic [31:0],
    localparam int SEL_W       = (NUM_OUTPUTS > 1) ? $clog2(NUM_OUTPUTS) : 1
) (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire [SEL_W-1:0]                  sel,
    input  wire                              valid_in,
    output logic                             ready_in,
    input  wire payload_t                    data_in,
    output logic [NUM_OUTPUTS-1:0]           valid_out,
    input  wire [NUM_OUTPUTS-1:0]            ready_out,
    output payload_t [NUM_OUTPUTS-1:0]       data_out
);

    logic [NUM_OUTPUTS-1:0] sel_onehot;

    assign sel_onehot = NUM_OUTPUTS'(1) << sel;

    if (BUFFERED) begin : g_buffered

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // one register per output
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        logic [NUM_OUTPUTS-1:0]     out_valid;
        payload_t [NUM_OUTPUTS-1:0] out_data;
        logic [NUM_OUTPUTS-1:0]     can_load;
        logic [NUM_OUTPUTS-1:0]     load;

        assign can_load = ~out_valid | ready_out;     // empty or draining.
        assign load     = {NUM_OUTPUTS{valid_in}} & sel_onehot & can_load;
        assign ready_in = can_load[sel];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                out_valid <= '0;
            end else begin
                out_valid <= load | (out_valid & ~ready_out);
            end
        end

        always_ff @(posedge clk) begin
            for (int i = 0; i < NUM_OUTPUTS; i++) begin
                if (load[i]) begin
                    out_data[i] <= data_in;
                end
            end
        end

        assign valid_out = out_valid;
        assign data_out  = out_data;

    end else begin : g_direct

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // combinational routing
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        assign valid_out = {NUM_OUTPUTS{valid_in}} & sel_onehot;
        assign ready_in  = ready_out[sel];            // only selected ready returns.

        for (genvar i = 0; i < NUM_OUTPUTS; i++) begin : g_out
            assign data_out[i] = data_in;
        end

    end

endmodule

`default_nettype wire

/* rtl/smem_pkg.sv */
`default_nettype none

package smem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int addr_w     = 10;                // word address.
    localparam int data_w     = 32;
    localparam int byteen_w   = data_w / 8;        // one enable per byte.
    localparam int tag_w      = 6;                 // requester tag.
    localparam int num_banks  = 2;
    localparam int sel_w      = $clog2(num_banks); // bank select field.
    localparam int bank_tag_w = tag_w - sel_w;     // tag once select is removed.

    typedef logic [bank_tag_w-1:0] bank_tag_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // requests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [addr_w-1:0]   addr;
        logic                rw;      // set for write.
        logic [byteen_w-1:0] byteen;
        logic [data_w-1:0]   data;
    } core_req_t;

    typedef struct packed {
        bank_tag_t           tag;
        logic [addr_w-1:0]   addr;
        logic                rw;
        logic [byteen_w-1:0] byteen;
        logic [data_w-1:0]   data;
    } bank_req_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read responses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] data;
    } core_rsp_t;

    typedef struct packed {
        bank_tag_t         tag;
        logic [data_w-1:0] data;
    } bank_rsp_t;

endpackage

`default_nettype wire
